/* rtl/fft_pkg.sv */
package fft_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and counts
    //////////////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 16;
    // one guard bit above and one below the sample
    localparam int WIDE_W   = 18;
    localparam int N_POINTS = 16;
    localparam int N_BFLY   = 8;
    localparam int N_STAGES = 4;
    localparam int IDX_W    = 4;
    localparam int TW_W     = 3;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [WIDE_W-1:0]   wide_t;
    // Q16, 1.0 is 0x10000
    typedef logic signed [WIDE_W-1:0]   coef_t;
    typedef sample_t                    sample_frame_t [N_POINTS];
    typedef logic [IDX_W-1:0]           idx_t;
    typedef logic [TW_W-1:0]            tw_idx_t;

    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,
        S_STAGE1 = 3'd1,
        S_STAGE2 = 3'd2,
        S_STAGE3 = 3'd3,
        S_STAGE4 = 3'd4,
        S_DONE   = 3'd7
    } fft_state_e;

    //////////////////////////////////////////////////////////////////////
    // twiddles, cos and -sin of 2*pi*k/16
    //////////////////////////////////////////////////////////////////////

    localparam coef_t W_REAL [N_BFLY] = '{
        18'sh10000, 18'sh0EC83, 18'sh0B504, 18'sh061F7,
        18'sh00000, 18'sh39E09, 18'sh34AFC, 18'sh3137D
    };

    localparam coef_t W_IMAG [N_BFLY] = '{
        18'sh00000, 18'sh39E09, 18'sh34AFC, 18'sh3137D,
        18'sh30000, 18'sh3137D, 18'sh34AFC, 18'sh39E09
    };

endpackage

/* rtl/fft_stage_if.sv */
`timescale 1ns/1ps

interface fft_stage_if;
    import fft_pkg::*;

    // frame capture into bank 1
    logic    load;
    // one butterfly stage this cycle
    logic    compute;
    // read bank 1, write bank 2 (otherwise the reverse)
    logic    write_bank2;

    // pair addresses and twiddle select per butterfly
    idx_t    a_idx  [N_BFLY];
    idx_t    b_idx  [N_BFLY];
    tw_idx_t tw_idx [N_BFLY];

    modport ctrl (
        output load,
        output compute,
        output write_bank2,
        output a_idx,
        output b_idx,
        output tw_idx
    );

    modport core (
        input load,
        input compute,
        input write_bank2,
        input a_idx,
        input b_idx,
        input tw_idx
    );

endinterface

/* rtl/fft_input_buffer.sv */
`timescale 1ns/1ps

module fft_input_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  fft_pkg::sample_t       fir_d,
    input  logic                   fir_valid,
    output fft_pkg::sample_frame_t frame,
    output logic                   frame_ready
);
    import fft_pkg::*;

    idx_t wr_ptr;

    // slot counter wraps after slot 15 on its own
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= fir_valid && (wr_ptr == idx_t'(N_POINTS - 1));
            if (fir_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fir_valid) begin
            frame[wr_ptr] <= fir_d;
        end
    end

    // a full frame needs 16 samples, so never two ready pulses back to back
    a_ready_single: assert property (
        @(posedge clk) disable iff (rst)
        frame_ready |=> !frame_ready
    );

endmodule

/* rtl/fft_stage_ctrl.sv */
`timescale 1ns/1ps

module fft_stage_ctrl (
    input  logic      clk,
    input  logic      rst,
    input  logic      frame_ready,
    fft_stage_if.ctrl stage,
    output logic      result_ready
);
    import fft_pkg::*;

    fft_state_e state;
    fft_state_e state_nxt;
    logic [1:0] stg;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            S_IDLE:   state_nxt = frame_ready ? S_STAGE1 : S_IDLE;
            S_STAGE1: state_nxt = S_STAGE2;
            S_STAGE2: state_nxt = S_STAGE3;
            S_STAGE3: state_nxt = S_STAGE4;
            S_STAGE4: state_nxt = S_DONE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state             <= S_IDLE;
            stage.write_bank2 <= 1'b1;
        end else begin
            state <= state_nxt;
            // first stage always lands in bank 2
            if (state == S_IDLE) begin
                stage.write_bank2 <= 1'b1;
            end else if (stage.compute) begin
                stage.write_bank2 <= !stage.write_bank2;
            end
        end
    end

    assign stage.load    = (state == S_IDLE) && frame_ready;
    assign stage.compute = state inside {S_STAGE1, S_STAGE2, S_STAGE3, S_STAGE4};
    assign result_ready  = (state == S_DONE);

    //////////////////////////////////////////////////////////////////////
    // pair and twiddle addressing
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            S_STAGE2: stg = 2'd1;
            S_STAGE3: stg = 2'd2;
            S_STAGE4: stg = 2'd3;
            default:  stg = 2'd0;
        endcase
    end

    // distance 8, 4, 2, 1; twiddle stride doubles each stage
    always_comb begin
        int span;
        int lo;
        span = N_BFLY >> stg;
        for (int k = 0; k < N_BFLY; k++) begin
            lo              = k % span;
            stage.a_idx[k]  = '0;
            stage.b_idx[k]  = '0;
            stage.tw_idx[k] = '0;
            if (stage.compute) begin
                stage.a_idx[k]  = idx_t'((k - lo) * 2 + lo);
                stage.b_idx[k]  = idx_t'((k - lo) * 2 + lo + span);
                stage.tw_idx[k] = tw_idx_t'(lo << stg);
            end
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {S_IDLE, S_STAGE1, S_STAGE2, S_STAGE3, S_STAGE4, S_DONE}
    );

endmodule

/* rtl/fft_butterfly.sv */
`timescale 1ns/1ps

module fft_butterfly (
    input  fft_pkg::wide_t a,
    input  fft_pkg::wide_t b,
    input  fft_pkg::wide_t c,
    input  fft_pkg::wide_t d,
    input  fft_pkg::coef_t w_real,
    input  fft_pkg::coef_t w_imag,
    output fft_pkg::wide_t out_a_real,
    output fft_pkg::wide_t out_a_imag,
    output fft_pkg::wide_t out_b_real,
    output fft_pkg::wide_t out_b_imag
);
    import fft_pkg::*;

    wide_t ac_diff;
    wide_t bd_diff;
    wide_t db_diff;

    logic signed [2*WIDE_W-1:0] p_ac_wr;
    logic signed [2*WIDE_W-1:0] p_db_wi;
    logic signed [2*WIDE_W-1:0] p_ac_wi;
    logic signed [2*WIDE_W-1:0] p_bd_wr;

    assign ac_diff = a - c;
    assign bd_diff = b - d;
    assign db_diff = d - b;

    assign p_ac_wr = ac_diff * w_real;
    assign p_db_wi = db_diff * w_imag;
    assign p_ac_wi = ac_diff * w_imag;
    assign p_bd_wr = bd_diff * w_real;

    assign out_a_real = a + c;
    assign out_a_imag = b + d;
    // drop the Q16 fraction before summing
    assign out_b_real = p_ac_wr[33:16] + p_db_wi[33:16];
    assign out_b_imag = p_ac_wi[33:16] + p_bd_wr[33:16];

endmodule

/* rtl/fft_core.sv */
`timescale 1ns/1ps

module fft_core (
    input  logic                   clk,
    input  logic                   rst,
    input  fft_pkg::sample_frame_t frame,
    fft_stage_if.core              stage,
    output fft_pkg::sample_frame_t bins_real,
    output fft_pkg::sample_frame_t bins_imag
);
    import fft_pkg::*;

    wide_t bank1_re [N_POINTS];
    wide_t bank1_im [N_POINTS];
    wide_t bank2_re [N_POINTS];
    wide_t bank2_im [N_POINTS];

    // read side of the ping-pong pair
    wide_t rd_re [N_POINTS];
    wide_t rd_im [N_POINTS];

    wide_t bf_a_re [N_BFLY];
    wide_t bf_a_im [N_BFLY];
    wide_t bf_b_re [N_BFLY];
    wide_t bf_b_im [N_BFLY];

    function automatic idx_t bit_rev(idx_t i);
        idx_t r;
        for (int j = 0; j < IDX_W; j++) begin
            r[j] = i[IDX_W-1-j];
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < N_POINTS; i++) begin
            rd_re[i] = stage.write_bank2 ? bank1_re[i] : bank2_re[i];
            rd_im[i] = stage.write_bank2 ? bank1_im[i] : bank2_im[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // butterflies
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < N_BFLY; k++) begin : g_bfly
        fft_butterfly bfly_i (
            .a          (rd_re[stage.a_idx[k]]),
            .b          (rd_im[stage.a_idx[k]]),
            .c          (rd_re[stage.b_idx[k]]),
            .d          (rd_im[stage.b_idx[k]]),
            .w_real     (W_REAL[stage.tw_idx[k]]),
            .w_imag     (W_IMAG[stage.tw_idx[k]]),
            .out_a_real (bf_a_re[k]),
            .out_a_imag (bf_a_im[k]),
            .out_b_real (bf_b_re[k]),
            .out_b_imag (bf_b_im[k])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // load and in-place writeback
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (stage.load) begin
            for (int i = 0; i < N_POINTS; i++) begin
                bank1_re[i] <= {frame[i][SAMPLE_W-1], frame[i], 1'b0};
                bank1_im[i] <= '0;
            end
        end else if (stage.compute) begin
            for (int k = 0; k < N_BFLY; k++) begin
                if (stage.write_bank2) begin
                    bank2_re[stage.a_idx[k]] <= bf_a_re[k];
                    bank2_im[stage.a_idx[k]] <= bf_a_im[k];
                    bank2_re[stage.b_idx[k]] <= bf_b_re[k];
                    bank2_im[stage.b_idx[k]] <= bf_b_im[k];
                end else begin
                    bank1_re[stage.a_idx[k]] <= bf_a_re[k];
                    bank1_im[stage.a_idx[k]] <= bf_a_im[k];
                    bank1_re[stage.b_idx[k]] <= bf_b_re[k];
                    bank1_im[stage.b_idx[k]] <= bf_b_im[k];
                end
            end
        end
    end

    // stage 4 ends in bank 1 in bit-reversed order
    for (genvar k = 0; k < N_POINTS; k++) begin : g_bins
        assign bins_real[k] = bank1_re[bit_rev(idx_t'(k))][SAMPLE_W:1];
        assign bins_imag[k] = bank1_im[bit_rev(idx_t'(k))][SAMPLE_W:1];
    end

    a_load_vs_compute: assert property (
        @(posedge clk) disable iff (rst)
        !(stage.load && stage.compute)
    );

endmodule

/* rtl/fft_output_ctrl.sv */
`timescale 1ns/1ps

module fft_output_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   result_ready,
    input  fft_pkg::sample_frame_t bins_real,
    input  fft_pkg::sample_frame_t bins_imag,
    input  logic                   fir_valid,
    output fft_pkg::sample_frame_t fft_d,
    output logic                   fft_valid,
    output logic                   done
);
    import fft_pkg::*;

    logic ready_d1;
    logic ready_d2;
    // 0 real beat, 1 imag beat
    logic imag_sel;

    logic fir_d1;
    logic valid_d1;
    logic in_end;
    logic out_end;
    logic drain;
    logic drain_hit;

    //////////////////////////////////////////////////////////////////////
    // two-beat output
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_d1 <= 1'b0;
            ready_d2 <= 1'b0;
            imag_sel <= 1'b0;
        end else begin
            ready_d1 <= result_ready;
            ready_d2 <= ready_d1;
            if (result_ready || ready_d1) begin
                imag_sel <= !imag_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (result_ready || ready_d1) begin
            for (int i = 0; i < N_POINTS; i++) begin
                fft_d[i] <= imag_sel ? bins_imag[i] : bins_real[i];
            end
        end
    end

    assign fft_valid = ready_d1 || ready_d2;

    //////////////////////////////////////////////////////////////////////
    // end of stream
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fir_d1   <= 1'b0;
            valid_d1 <= 1'b0;
            drain    <= 1'b0;
            done     <= 1'b0;
        end else begin
            fir_d1   <= fir_valid;
            valid_d1 <= fft_valid;
            done     <= drain_hit;
            if (drain_hit) begin
                drain <= 1'b0;
            end else if (in_end) begin
                drain <= 1'b1;
            end
        end
    end

    assign in_end  = fir_d1 && !fir_valid;
    assign out_end = valid_d1 && !fft_valid;
    // input fall on the same edge still counts
    assign drain_hit = (drain || in_end) && out_end;

    a_valid_two_beats: assert property (
        @(posedge clk) disable iff (rst)
        fft_valid ##1 fft_valid |=> !fft_valid
    );

endmodule

/* rtl/fft_top.sv */
`timescale 1ns/1ps

module fft_top (
    input  logic                   clk,
    input  logic                   rst,
    input  fft_pkg::sample_t       fir_d,
    input  logic                   fir_valid,
    output fft_pkg::sample_frame_t fft_d,
    output logic                   fft_valid,
    output logic                   done
);
    import fft_pkg::*;

    sample_frame_t frame;
    logic          frame_ready;
    sample_frame_t bins_real;
    sample_frame_t bins_imag;
    logic          result_ready;

    fft_stage_if stage_bus ();

    fft_input_buffer input_buffer_i (
        .clk         (clk),
        .rst         (rst),
        .fir_d       (fir_d),
        .fir_valid   (fir_valid),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    fft_stage_ctrl stage_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .frame_ready  (frame_ready),
        .stage        (stage_bus.ctrl),
        .result_ready (result_ready)
    );

    fft_core core_i (
        .clk       (clk),
        .rst       (rst),
        .frame     (frame),
        .stage     (stage_bus.core),
        .bins_real (bins_real),
        .bins_imag (bins_imag)
    );

    fft_output_ctrl output_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .result_ready (result_ready),
        .bins_real    (bins_real),
        .bins_imag    (bins_imag),
        .fir_valid    (fir_valid),
        .fft_d        (fft_d),
        .fft_valid    (fft_valid),
        .done         (done)
    );

endmodule

/* testbench/fft_tb.sv */
`timescale 1ns/1ps

module fft_tb;
    import fft_pkg::*;

    localparam int N_ROWS         = 12;
    localparam int N_FIXED        = 8;
    localparam int TIMEOUT_CYCLES = N_ROWS * N_POINTS + 40;

    // frame kinds
    localparam int K_CONST = 0;
    localparam int K_IMP0  = 1;
    localparam int K_IMP8  = 2;
    localparam int K_ALT   = 3;

    localparam int FIXED_KIND [N_FIXED] = '{
        K_CONST, K_IMP0, K_IMP8, K_ALT, K_CONST, K_IMP0, K_IMP8, K_ALT
    };
    localparam int FIXED_AMP [N_FIXED] = '{
        100, 1000, -500, 7, -2047, -1, 1, 2047
    };

    logic          clk;
    logic          rst;
    sample_t       fir_d;
    logic          fir_valid;
    sample_frame_t fft_d;
    logic          fft_valid;
    logic          done;

    // stimulus and expected real bins, one row per frame
    int kind_tab [N_ROWS];
    int amp_tab  [N_ROWS];
    int exp_tab  [N_ROWS][N_POINTS];

    integer seed;
    int     cycle      = 0;
    int     beat       = 0;
    int     pair_cnt   = 0;
    int     done_cnt   = 0;
    int     last_fall  = -10;
    logic   valid_prev = 1'b0;

    fft_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fft_d     (fft_d),
        .fft_valid (fft_valid),
        .done      (done)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reference model and checking
    //////////////////////////////////////////////////////////////////////

    task automatic fail_with(string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, int expected, int actual);
        if (expected !== actual) begin
            fail_with($sformatf("FAIL %s expected %h got %h", name, expected, actual));
        end
    endtask

    function automatic int frame_sample(int kind, int v, int n);
        case (kind)
            K_CONST: return v;
            K_IMP0:  return (n == 0) ? v : 0;
            K_IMP8:  return (n == 8) ? v : 0;
            default: return (n % 2 == 0) ? v : -v;
        endcase
    endfunction

    function automatic int expected_real(int kind, int v, int k);
        case (kind)
            K_CONST: return (k == 0) ? 16 * v : 0;
            K_IMP0:  return v;
            // half-cycle delay flips every odd bin
            K_IMP8:  return (k % 2 == 0) ? v : -v;
            default: return (k == 8) ? 16 * v : 0;
        endcase
    endfunction

    task automatic build_table();
        for (int r = 0; r < N_ROWS; r++) begin
            if (r < N_FIXED) begin
                kind_tab[r] = FIXED_KIND[r];
                amp_tab[r]  = FIXED_AMP[r];
            end else begin
                kind_tab[r] = r % 4;
                // keeps 16v inside the 16-bit output
                amp_tab[r]  = $random(seed) % 2048;
            end
            for (int k = 0; k < N_POINTS; k++) begin
                exp_tab[r][k] = expected_real(kind_tab[r], amp_tab[r], k);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (fft_valid) begin
                if (pair_cnt >= N_ROWS) begin
                    fail_with("fft_valid rose after every frame already had its result");
                end
                if (beat == 0) begin
                    for (int k = 0; k < N_POINTS; k++) begin
                        check_value($sformatf("fft_d[%0d] real, frame %0d", k, pair_cnt),
                                    exp_tab[pair_cnt][k], fft_d[k]);
                    end
                end else if (beat == 1) begin
                    for (int k = 0; k < N_POINTS; k++) begin
                        check_value($sformatf("fft_d[%0d] imag, frame %0d", k, pair_cnt),
                                    0, fft_d[k]);
                    end
                end else begin
                    fail_with("fft_valid stayed high for more than two cycles");
                end
                beat++;
            end else if (valid_prev) begin
                check_value("fft_valid beats", 2, beat);
                beat      = 0;
                pair_cnt++;
                last_fall = cycle;
            end
            if (done) begin
                if (done_cnt != 0) begin
                    fail_with("done pulsed more than once");
                end
                if (pair_cnt != N_ROWS) begin
                    fail_with("done pulsed before the last result frame left");
                end
                check_value("done cycle", last_fall + 1, cycle);
                done_cnt++;
            end
            valid_prev = fft_valid;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_with($sformatf("timeout, no done pulse after %0d cycles", cycle));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        fir_d     = '0;
        fir_valid = 1'b0;
        seed      = 32'hddfe;
        build_table();

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // frames back to back, fir_valid never drops in between
        for (int r = 0; r < N_ROWS; r++) begin
            for (int n = 0; n < N_POINTS; n++) begin
                fir_valid <= 1'b1;
                fir_d     <= sample_t'(frame_sample(kind_tab[r], amp_tab[r], n));
                @(posedge clk);
            end
        end
        fir_valid <= 1'b0;
        fir_d     <= '0;

        wait (done_cnt == 1);
        // a second pulse would be caught by the monitor
        repeat (4) @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* tb.f */
rtl/fft_pkg.sv
rtl/fft_stage_if.sv
rtl/fft_input_buffer.sv
rtl/fft_stage_ctrl.sv
rtl/fft_butterfly.sv
rtl/fft_core.sv
rtl/fft_output_ctrl.sv
rtl/fft_top.sv
testbench/fft_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module fft_tb -f tb.f
	out=$$(./obj_dir/Vfft_tb); echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
